/* include/spiAdc_macros.svh */
// Compile-time ADC settings; FIFO depth must be a power of two and NUM_BITS excludes the null bit
`ifndef SPIADC_MACROS_SVH
`define SPIADC_MACROS_SVH

// Clock cycles the ADC needs in its sampling phase
`define SPIADC_SAMPLE_TIME 2

// Data bits per conversion, null bit not counted
`define SPIADC_NUM_BITS 12

// Sample words held before overrun
`define SPIADC_FIFO_DEPTH 4

`endif

/* hdl/spiAdcPkg.sv */
// Shared ADC reader types; widths follow the macro header, so FIFO depth must be a power of two
`include "spiAdc_macros.svh"

package spiAdcPkg;

    // One conversion result, null bit already removed
    typedef logic [`SPIADC_NUM_BITS-1:0] sampleT;

    // Conversion frame phases
    typedef enum logic [1:0] {
        IDLE,
        CHIPENABLE,
        SAMPLE,
        TRANSFER
    } fsmStateT;

    localparam int FIFO_ADDR_W = $clog2(`SPIADC_FIFO_DEPTH);

    // Extra MSB separates full from empty
    typedef logic [FIFO_ADDR_W:0] fifoPtrT;

endpackage

/* hdl/SpiFsm.sv */
// Free-running frames with no stall input; frame length is SAMPLE_TIME+NUM_BITS+2 cycles
`include "spiAdc_macros.svh"

module SpiFsm
    import spiAdcPkg::*;
(
    input  logic clk,
    input  logic rst,

    output logic dataInEnable,
    output logic chipEnable,
    output logic busClkEnable,
    output logic dataOutValid
);

    // Counter must reach NUM_BITS in TRANSFER and SAMPLE_TIME-1 in SAMPLE
    localparam int CNT_MAX = (`SPIADC_SAMPLE_TIME > `SPIADC_NUM_BITS) ?
                             `SPIADC_SAMPLE_TIME : `SPIADC_NUM_BITS;
    localparam int CNT_W   = $clog2(CNT_MAX + 1);

    fsmStateT         state;
    fsmStateT         nextState;
    logic [CNT_W-1:0] cnt;                  // Cycles spent in current state
    logic             chipEnableInt;        // Start pulse before the half-cycle shift

    // Shared state counter, cleared on every transition
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (state != nextState) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    // End of TRANSFER marks a finished word
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dataOutValid <= 1'b0;
        end else begin
            dataOutValid <= (state == TRANSFER) && (nextState == CHIPENABLE);
        end
    end

    // Start pulse moved to the falling edge so the ADC sees it mid-cycle
    always_ff @(negedge clk or posedge rst) begin
        if (rst) begin
            chipEnable <= 1'b0;
        end else begin
            chipEnable <= chipEnableInt;
        end
    end

    always_comb begin
        nextState     = state;
        dataInEnable  = 1'b0;
        chipEnableInt = 1'b0;
        busClkEnable  = 1'b0;

        case (state)
            IDLE: begin
                nextState = CHIPENABLE;
            end

            CHIPENABLE: begin
                nextState     = SAMPLE;
                chipEnableInt = 1'b1;
                busClkEnable  = 1'b1;       // Bus clock starts with the frame
            end

            SAMPLE: begin
                busClkEnable = 1'b1;
                if (cnt == CNT_W'(`SPIADC_SAMPLE_TIME - 1)) begin
                    nextState = TRANSFER;
                end
            end

            TRANSFER: begin
                busClkEnable = 1'b1;
                dataInEnable = 1'b1;
                // Null bit plus NUM_BITS data bits
                if (cnt == CNT_W'(`SPIADC_NUM_BITS)) begin
                    nextState = CHIPENABLE;
                end
            end

            default: begin
                nextState = IDLE;
            end
        endcase
    end

endmodule

/* hdl/AdcShiftIn.sv */
// Gated bus clock and MSB-first capture; word is valid only while dataOutValid is high
`include "spiAdc_macros.svh"

module AdcShiftIn
    import spiAdcPkg::*;
(
    input  logic   clk,
    input  logic   rst,

    input  logic   busClkEnable,
    input  logic   dataInEnable,
    input  logic   dataOutValid,
    input  logic   adcData,

    output logic   sclk,
    output sampleT sample
);

    logic                      clkGate;     // Enable held stable while clk is high
    logic [`SPIADC_NUM_BITS:0] shiftReg;    // Null bit lands in the MSB

    // Enable changes only while clk is low, so the AND cannot glitch
    always_ff @(negedge clk or posedge rst) begin
        if (rst) begin
            clkGate <= 1'b0;
        end else begin
            clkGate <= busClkEnable;
        end
    end

    assign sclk = clk & clkGate;

    // Serial capture, oldest bit ends up on top
    always_ff @(posedge clk) begin
        if (dataOutValid) begin
            shiftReg <= '0;                 // Word taken, start next frame clean
        end else if (dataInEnable) begin
            shiftReg <= {shiftReg[`SPIADC_NUM_BITS-1:0], adcData};
        end
    end

    // Capture is idle during the valid cycle, so the word holds still
    // The null bit in the top position is dropped here
    assign sample = shiftReg[`SPIADC_NUM_BITS-1:0];

endmodule

/* hdl/SampleFifo.sv */
// Circular sample buffer; pushes into a full buffer are lost and overrun stays set until reset
`include "spiAdc_macros.svh"

module SampleFifo
    import spiAdcPkg::*;
(
    input  logic   clk,
    input  logic   rst,

    input  logic   push,
    input  sampleT sampleIn,

    input  logic   pop,
    output sampleT sampleOut,
    output logic   sampleAvail,
    output logic   overrun
);

    sampleT  mem [`SPIADC_FIFO_DEPTH];
    fifoPtrT wrPtr;
    fifoPtrT rdPtr;
    logic    full;
    logic    empty;
    logic    doPush;
    logic    doPop;

    // Same index with differing wrap bits means full
    assign empty = (wrPtr == rdPtr);
    assign full  = (wrPtr[FIFO_ADDR_W] != rdPtr[FIFO_ADDR_W]) &&
                   (wrPtr[FIFO_ADDR_W-1:0] == rdPtr[FIFO_ADDR_W-1:0]);

    assign doPush = push && !full;
    assign doPop  = pop && !empty;          // Pop on empty is ignored

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr[FIFO_ADDR_W-1:0]] <= sampleIn;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wrPtr <= '0;
        end else if (doPush) begin
            wrPtr <= wrPtr + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdPtr <= '0;
        end else if (doPop) begin
            rdPtr <= rdPtr + 1'b1;
        end
    end

    // Sticky, the lost word cannot be recovered
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            overrun <= 1'b0;
        end else if (push && full) begin
            overrun <= 1'b1;
        end
    end

    // Head word always visible
    assign sampleOut   = mem[rdPtr[FIFO_ADDR_W-1:0]];
    assign sampleAvail = !empty;

endmodule

/* hdl/SpiAdcReader.sv */
// Read-only serial ADC reader; no MOSI, no channel select, samples queued until popped
module SpiAdcReader
    import spiAdcPkg::*;
(
    input  logic   clk,
    input  logic   rst,

    input  logic   adcData,
    input  logic   pop,

    output logic   sclk,
    output logic   convStart,
    output sampleT sampleOut,
    output logic   sampleAvail,
    output logic   overrun
);

    logic   busClkEnable;
    logic   dataInEnable;
    logic   dataOutValid;   // Also the FIFO push strobe
    sampleT sample;

    SpiFsm fsm (
        .clk          (clk),
        .rst          (rst),
        .dataInEnable (dataInEnable),
        .chipEnable   (convStart),      // Goes straight to the ADC
        .busClkEnable (busClkEnable),
        .dataOutValid (dataOutValid)
    );

    AdcShiftIn shiftIn (
        .clk          (clk),
        .rst          (rst),
        .busClkEnable (busClkEnable),
        .dataInEnable (dataInEnable),
        .dataOutValid (dataOutValid),
        .adcData      (adcData),
        .sclk         (sclk),
        .sample       (sample)
    );

    SampleFifo fifo (
        .clk         (clk),
        .rst         (rst),
        .push        (dataOutValid),
        .sampleIn    (sample),
        .pop         (pop),
        .sampleOut   (sampleOut),
        .sampleAvail (sampleAvail),
        .overrun     (overrun)
    );

endmodule

/* bench/AdcModel.sv */
// Behavioral serial ADC; list entries past LIST_LEN read as zero, don't-care positions drive high
`include "spiAdc_macros.svh"

module AdcModel
    import spiAdcPkg::*;
#(
    parameter int LIST_LEN = 64
)
(
    input  logic sclk,
    input  logic convStart,
    output logic adcData
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] valueList [LIST_LEN];     // Filled by the testbench before the frames run

    int      takeIdx    = 0;               // Next list entry to convert
    int      frameCount = 0;
    realtime startTime  = -1.0;            // Time of the latest conversion start
    sampleT  current    = '0;

    int      seenFrame  = 0;
    int      pos        = 0;               // Position in the serial stream
    logic    bitOut     = 1'b1;

    // Serial stream: sampling positions, null bit, then data MSB first
    function automatic logic streamBit(input sampleT value, input int position);
        sampleT shifted;
        if (position < `SPIADC_SAMPLE_TIME) begin
            return 1'b1;
        end else if (position == `SPIADC_SAMPLE_TIME) begin
            return 1'b0;                    // Null bit
        end else if (position <= `SPIADC_SAMPLE_TIME + `SPIADC_NUM_BITS) begin
            shifted = value >> (`SPIADC_SAMPLE_TIME + `SPIADC_NUM_BITS - position);
            return shifted[0];
        end else begin
            return 1'b1;
        end
    endfunction

    // A new conversion takes the next value from the list
    always @(posedge convStart) begin
        startTime = $realtime;
        if (takeIdx < LIST_LEN) begin
            current = valueList[takeIdx][`SPIADC_NUM_BITS-1:0];
        end else begin
            current = '0;
        end
        takeIdx    = takeIdx + 1;
        frameCount = frameCount + 1;
    end

    // Bus clock falling edges step through the stream
    // An edge in the same time step as the start pulse belongs to the old frame
    always @(negedge sclk) begin
        if (frameCount != 0 && $realtime != startTime) begin
            if (seenFrame != frameCount) begin
                seenFrame = frameCount;
                pos       = 0;
            end else begin
                pos = pos + 1;
            end
            bitOut = streamBit(current, pos);
        end
    end

    assign adcData = bitOut;

endmodule

/* bench/tbSpiAdcReader.sv */
// Needs immediate assertions enabled; the model list bounds the number of frames per run
`include "spiAdc_macros.svh"

module tbSpiAdcReader
    import spiAdcPkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int FRAME_CYCLES = `SPIADC_SAMPLE_TIME + `SPIADC_NUM_BITS + 2;
    localparam int NUM_VALUES   = 64;
    localparam int WAIT_LIMIT   = 2 * FRAME_CYCLES + 8;     // Cycles allowed for one wait
    localparam int STIM_DELAY   = 10;

    logic   clk = 1'b0;
    logic   rst;
    logic   pop;
    logic   adcData;
    logic   sclk;
    logic   convStart;
    sampleT sampleOut;
    logic   sampleAvail;
    logic   overrun;

    int          seed = 32'h20c8_64e8;
    logic [31:0] refQueue [$];
    int          testBase;              // List entry of the first frame after reset
    int          popStart;
    int          popCount    = 0;
    int          checkErrors = 0;
    int          mainErrors;
    int          errorsAtStart;
    int          testsPassed;
    int          testsFailed;
    bit          timedOut;

    always #50 clk = ~clk;

    SpiAdcReader dut (
        .clk         (clk),
        .rst         (rst),
        .adcData     (adcData),
        .pop         (pop),
        .sclk        (sclk),
        .convStart   (convStart),
        .sampleOut   (sampleOut),
        .sampleAvail (sampleAvail),
        .overrun     (overrun)
    );

    AdcModel #(.LIST_LEN(NUM_VALUES)) adc (
        .sclk      (sclk),
        .convStart (convStart),
        .adcData   (adcData)
    );

    // Sample word the ADC should deliver for a list entry
    function automatic sampleT expectedSample(input int idx);
        logic [31:0] raw;
        raw = refQueue[idx];
        return raw[`SPIADC_NUM_BITS-1:0];
    endfunction

    // Every taken pop is compared with the reference, in list order
    always @(negedge clk) begin
        int     idx;
        sampleT expected;
        if (!rst && pop && sampleAvail) begin
            idx = testBase + popCount - popStart;
            if (idx < refQueue.size()) begin
                expected = expectedSample(idx);
                assert (sampleOut == expected) else begin
                    $display("FAIL sampleOut expected 0x%03h got 0x%03h (entry %0d)",
                             expected, sampleOut, idx);
                    checkErrors++;
                end
            end else begin
                $display("A word was popped past the end of the reference list");
                checkErrors++;
            end
            popCount++;
        end
    end

    task automatic nextCycle();
        @(posedge clk);
        #STIM_DELAY;
    endtask

    task automatic checkLevel(input string name, input logic actual, input logic expected);
        assert (actual == expected) else begin
            $display("FAIL %s expected 0x%0h got 0x%0h at %0t", name, expected, actual, $time);
            mainErrors++;
        end
    endtask

    task automatic checkWord(input string name, input int actual, input int expected);
        assert (actual == expected) else begin
            $display("FAIL %s expected 0x%0h got 0x%0h at %0t", name, expected, actual, $time);
            mainErrors++;
        end
    endtask

    task automatic reportTimeout(input string what);
        if (!timedOut) begin
            $display("Timeout: %s within the cycle limit", what);
        end
        timedOut = 1'b1;
    endtask

    task automatic queueValue(input logic [31:0] value);
        adc.valueList[refQueue.size()] = value;
        refQueue.push_back(value);
    endtask

    task automatic checkResetOutputs();
        checkLevel("convStart", convStart, 1'b0);
        checkLevel("sclk", sclk, 1'b0);
        checkLevel("sampleAvail", sampleAvail, 1'b0);
        checkLevel("overrun", overrun, 1'b0);
    endtask

    task automatic applyReset(input bit checkOutputs);
        rst = 1'b1;
        pop = 1'b0;
        repeat (16) begin
            nextCycle();
            if (checkOutputs) begin
                checkResetOutputs();
            end
        end
        rst      = 1'b0;
        testBase = adc.takeIdx;         // First start pulse after release takes this entry
        popStart = popCount;
    endtask

    task automatic waitAvail();
        int cyc;
        cyc = 0;
        while (!sampleAvail && cyc < WAIT_LIMIT && !timedOut) begin
            nextCycle();
            cyc++;
        end
        if (!sampleAvail) begin
            reportTimeout("sampleAvail did not rise");
        end
    endtask

    task automatic popOne();
        waitAvail();
        if (!timedOut) begin
            pop = 1'b1;
            nextCycle();
            pop = 1'b0;
        end
    endtask

    // Counts rising convStart samples taken once per cycle
    task automatic waitFrames(input int count);
        int   seen;
        int   cyc;
        logic prev;
        seen = 0;
        cyc  = 0;
        prev = convStart;
        while (seen < count && cyc < (count + 2) * FRAME_CYCLES && !timedOut) begin
            nextCycle();
            cyc++;
            if (convStart && !prev) begin
                seen++;
            end
            prev = convStart;
        end
        if (seen < count) begin
            reportTimeout("the expected convStart pulses did not arrive");
        end
    endtask

    task automatic testResetState();
        applyReset(1'b1);
        checkResetOutputs();            // Right after release
        nextCycle();
        checkResetOutputs();
    endtask

    task automatic testFrameTiming();
        int cyc;
        int run;
        int rises;
        int lastRise;
        cyc      = 0;
        run      = 0;
        rises    = 0;
        lastRise = -1;
        while ((rises < 4 || run != 0) && cyc < 5 * FRAME_CYCLES) begin
            if (convStart) begin
                run++;
                if (run == 1) begin
                    if (lastRise >= 0) begin
                        checkWord("convStart period", cyc - lastRise, FRAME_CYCLES);
                    end
                    lastRise = cyc;
                    rises++;
                end
            end else begin
                if (run != 0) begin
                    checkWord("convStart width", run, 1);
                end
                run = 0;
            end
            nextCycle();
            cyc++;
        end
        if (rises < 4 || run != 0) begin
            reportTimeout("four complete convStart pulses were not seen");
        end
    endtask

    task automatic testDataCapture();
        applyReset(1'b0);
        for (int n = 0; n < 20; n++) begin
            popOne();
        end
        if (!timedOut) begin
            checkLevel("overrun", overrun, 1'b0);
        end
    endtask

    task automatic testFifoOrder();
        applyReset(1'b0);
        waitFrames(4);                  // Three words queued when the fourth frame starts
        for (int n = 0; n < 3; n++) begin
            popOne();
        end
        if (!timedOut) begin
            checkLevel("sampleAvail", sampleAvail, 1'b0);
        end
    endtask

    task automatic testOverrun();
        applyReset(1'b0);
        waitFrames(`SPIADC_FIFO_DEPTH + 3);
        checkLevel("overrun", overrun, 1'b1);
        for (int n = 0; n < `SPIADC_FIFO_DEPTH; n++) begin
            popOne();
            checkLevel("overrun", overrun, 1'b1);
        end
        checkLevel("sampleAvail", sampleAvail, 1'b0);   // Two words were dropped
        waitAvail();
        if (!timedOut) begin
            checkWord("sampleOut", int'(sampleOut),
                      int'(expectedSample(testBase + `SPIADC_FIFO_DEPTH + 2)));
            checkLevel("overrun", overrun, 1'b1);
        end
    endtask

    task automatic startTest();
        errorsAtStart = mainErrors + checkErrors;
    endtask

    task automatic endTest(input int num, input string name);
        if (timedOut || mainErrors + checkErrors != errorsAtStart) begin
            $display("Test %0d %s: failed", num, name);
            testsFailed++;
        end else begin
            $display("Test %0d %s: passed", num, name);
            testsPassed++;
        end
    endtask

    initial begin
        logic [31:0] value;
        rst         = 1'b1;
        pop         = 1'b0;
        mainErrors  = 0;
        testsPassed = 0;
        testsFailed = 0;
        testBase    = 0;
        popStart    = 0;
        timedOut    = 1'b0;

        for (int i = 0; i < NUM_VALUES; i++) begin
            value = $random(seed);
            queueValue(value);
        end

        startTest();
        testResetState();
        endTest(1, "reset state");

        startTest();
        if (!timedOut) begin
            testFrameTiming();
        end
        endTest(2, "frame timing");

        startTest();
        if (!timedOut) begin
            testDataCapture();
        end
        endTest(3, "data capture");

        startTest();
        if (!timedOut) begin
            testFifoOrder();
        end
        endTest(4, "FIFO ordering");

        startTest();
        if (!timedOut) begin
            testOverrun();
        end
        endTest(5, "overrun");

        $display("Summary: %0d tests passed, %0d tests failed, %0d check errors",
                 testsPassed, testsFailed, mainErrors + checkErrors);
        if (timedOut || mainErrors + checkErrors != 0) begin
            $display("Result: FAILED");
        end else begin
            $display("Result: PASSED");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+include
hdl/spiAdcPkg.sv
hdl/SpiFsm.sv
hdl/AdcShiftIn.sv
hdl/SampleFifo.sv
hdl/SpiAdcReader.sv
bench/AdcModel.sv
bench/tbSpiAdcReader.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and decide pass or fail from the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --assert --timescale 1ns/100ps --top-module tbSpiAdcReader \
    -Mdir obj_dir -o simv -f filelist.f > build.log 2>&1 ||
    { cat build.log; echo "Verilator build failed"; exit 1; }

(./obj_dir/simv > sim.log 2>&1 || true) && cat sim.log

grep -qx "Result: PASSED" sim.log && exit 0 || exit 1
